/* hdl/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// on-chip ram window, 32-bit words
`define RAM_BASE 32'h0000_1000
`define RAM_WORDS 1024

// machine timer
`define MTIME_ADDR 32'h0200_BFF8
`define MTIMECMP_ADDR 32'h0200_4000
// far enough out that nothing fires after reset
`define MTIMECMP_RESET 64'h8000_0000

// platform interrupt controller, offsets from base
`define PLIC_BASE 32'h0C00_0000
`define PLIC_PENDING_OFF 32'h1000
`define PLIC_ENABLE_OFF 32'h2000
// enable words per context
`define PLIC_CTX_ENABLE_STRIDE 32'h80
`define PLIC_THRESHOLD_OFF 32'h20_0000
`define PLIC_CLAIM_OFF 32'h20_0004
// threshold and claim per context
`define PLIC_CTX_STRIDE 32'h1000
`define PRIO_BITS 3

`endif

/* hdl/bus_pkg.sv */
`include "soc_config.svh"

package bus_pkg;

    // word index width into the ram bank
    localparam int RAM_AW = $clog2(`RAM_WORDS);

    // funct3 codes; stores reuse 0..3 as sb sh sw sd
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } ls_type_e;

    typedef enum logic [2:0] {none, ram, mtime, mtimecmp, plic} region_e;

    // which word of a doubleword is in flight
    typedef enum logic {first, second} step_e;

    // processor side, held for the whole access
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        read_enable;
        logic        write_enable;
        ls_type_e    ls_type;
    } bus_req_t;

    typedef struct packed {
        logic              strobe;
        logic              write;
        logic [RAM_AW-1:0] index;
        logic [1:0]        offset;
        ls_type_e          ls_type;
        logic [63:0]       data;
    } ram_req_t;

    typedef struct packed {
        logic        done;
        logic [63:0] data;
    } ram_rsp_t;

endpackage

/* hdl/irq_pkg.sv */
package irq_pkg;

    // the one wired source, also its pending/enable bit
    parameter int SOURCE_ID = 1;

    // hart 0 contexts
    typedef enum logic {m_mode = 1'b0, s_mode = 1'b1} context_e;

    typedef enum logic [2:0] {none, prio, pending, enable, threshold, claim} plic_reg_e;

    // one-cycle read or write strobe to the controller
    typedef struct packed {
        logic        read;
        logic        write;
        plic_reg_e   sel;
        context_e    ctx;
        logic [31:0] wdata;
    } plic_req_t;

endpackage

/* hdl/addr_decoder.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module addr_decoder (
    input  logic [63:0]        address,
    output bus_pkg::region_e   region,
    output irq_pkg::plic_reg_e plic_reg,
    output irq_pkg::context_e  plic_ctx
);

    logic [63:0] plic_off;

    // wraps for addresses below the base, never hits a small offset then
    assign plic_off = address - `PLIC_BASE;

    always_comb begin
        region = bus_pkg::none;
        plic_reg = irq_pkg::none;
        plic_ctx = irq_pkg::m_mode;
        // only the wired source has a priority slot
        case (plic_off)
            4 * irq_pkg::SOURCE_ID: plic_reg = irq_pkg::prio;
            `PLIC_PENDING_OFF: plic_reg = irq_pkg::pending;
            `PLIC_ENABLE_OFF: plic_reg = irq_pkg::enable;
            `PLIC_THRESHOLD_OFF: plic_reg = irq_pkg::threshold;
            `PLIC_CLAIM_OFF: plic_reg = irq_pkg::claim;
            // s-mode copies, one stride up
            `PLIC_ENABLE_OFF + `PLIC_CTX_ENABLE_STRIDE: begin
                plic_reg = irq_pkg::enable;
                plic_ctx = irq_pkg::s_mode;
            end
            `PLIC_THRESHOLD_OFF + `PLIC_CTX_STRIDE: begin
                plic_reg = irq_pkg::threshold;
                plic_ctx = irq_pkg::s_mode;
            end
            `PLIC_CLAIM_OFF + `PLIC_CTX_STRIDE: begin
                plic_reg = irq_pkg::claim;
                plic_ctx = irq_pkg::s_mode;
            end
            default: plic_reg = irq_pkg::none;
        endcase
        if (address >= `RAM_BASE && address < `RAM_BASE + 4 * `RAM_WORDS) begin
            region = bus_pkg::ram;
        end else if (address == `MTIME_ADDR) begin
            region = bus_pkg::mtime;
        end else if (address == `MTIMECMP_ADDR) begin
            region = bus_pkg::mtimecmp;
        end else if (plic_reg != irq_pkg::none) begin
            region = bus_pkg::plic;
        end
    end

endmodule

/* hdl/bus_controller.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module bus_controller (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  bus_pkg::bus_req_t  bus,
    input  bus_pkg::region_e   region,
    input  irq_pkg::plic_reg_e plic_reg,
    input  irq_pkg::context_e  plic_ctx,
    input  logic [63:0]        mtime,
    output bus_pkg::ram_req_t  ram_req,
    input  bus_pkg::ram_rsp_t  ram_rsp,
    output irq_pkg::plic_req_t plic_req,
    input  logic [31:0]        plic_rdata,
    output logic [63:0]        read_data,
    output logic               read_done,
    output logic               write_done
);

    // issue is the single strobe cycle, finish waits on the target
    typedef enum logic [1:0] {idle, issue, finish} ctl_state_e;

    ctl_state_e         state;
    bus_pkg::bus_req_t  req_q;
    bus_pkg::region_e   region_q;
    irq_pkg::plic_reg_e plic_reg_q;
    irq_pkg::context_e  plic_ctx_q;
    logic [63:0]        mtimecmp;
    logic [31:0]        ram_offset;
    logic               accept;
    logic               target_done;
    logic [63:0]        target_data;

    // both done levels are high exactly when idle
    assign accept = (state == idle) && (bus.read_enable || bus.write_enable);
    assign ram_offset = req_q.address[31:0] - `RAM_BASE;

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_q <= bus;
            region_q <= region;
            plic_reg_q <= plic_reg;
            plic_ctx_q <= plic_ctx;
        end
    end

    always_comb begin
        ram_req.strobe = (state == issue) && (region_q == bus_pkg::ram);
        ram_req.write = req_q.write_enable;
        ram_req.index = ram_offset[bus_pkg::RAM_AW+1:2];
        ram_req.offset = ram_offset[1:0];
        ram_req.ls_type = req_q.ls_type;
        ram_req.data = req_q.write_data;
    end

    always_comb begin
        plic_req.read = (state == issue) && (region_q == bus_pkg::plic) && req_q.read_enable;
        plic_req.write = (state == issue) && (region_q == bus_pkg::plic) && req_q.write_enable;
        plic_req.sel = plic_reg_q;
        plic_req.ctx = plic_ctx_q;
        plic_req.wdata = req_q.write_data[31:0];
    end

    // ram has variable latency, the rest answer right after the strobe
    // unmapped falls to zero data
    always_comb begin
        target_done = 1'b1;
        target_data = '0;
        case (region_q)
            bus_pkg::ram: begin
                target_done = ram_rsp.done;
                target_data = ram_rsp.data;
            end
            bus_pkg::mtime: target_data = mtime;
            bus_pkg::mtimecmp: target_data = mtimecmp;
            bus_pkg::plic: target_data = {32'd0, plic_rdata};
            default: target_data = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= idle;
            read_done <= 1'b1;
            write_done <= 1'b1;
            mtimecmp <= `MTIMECMP_RESET;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= issue;
                        read_done <= !bus.read_enable;
                        write_done <= !bus.write_enable;
                    end
                end
                issue: state <= finish;
                finish: begin
                    if (target_done) begin
                        state <= idle;
                        read_done <= 1'b1;
                        write_done <= 1'b1;
                        // mtime writes just complete
                        if (req_q.write_enable && region_q == bus_pkg::mtimecmp) begin
                            mtimecmp <= req_q.write_data;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // held until the next read finishes
    always_ff @(posedge CLOCK_50) begin
        if (state == finish && target_done && req_q.read_enable) begin
            read_data <= target_data;
        end
    end

endmodule

/* hdl/ram_bank.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module ram_bank (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::ram_req_t req,
    output bus_pkg::ram_rsp_t rsp
);

    logic [31:0]                mem [`RAM_WORDS];
    bus_pkg::step_e             step;
    bus_pkg::ram_req_t          req_q;
    logic                       active;
    logic                       wr;
    logic [bus_pkg::RAM_AW-1:0] idx;
    logic [31:0]                wdata;
    logic [3:0]                 lanes;
    logic                       done_q;
    logic [63:0]                data_q;

    // lane select then sign or zero extend
    function automatic logic [63:0] load_ext(input logic [31:0] word,
                                             input bus_pkg::ls_type_e kind,
                                             input logic [1:0] offset);
        logic [31:0] lane;
        lane = word >> (8 * offset);
        case (kind)
            bus_pkg::lb: return {{56{lane[7]}}, lane[7:0]};
            bus_pkg::lbu: return {56'd0, lane[7:0]};
            bus_pkg::lh: return {{48{lane[15]}}, lane[15:0]};
            bus_pkg::lhu: return {48'd0, lane[15:0]};
            bus_pkg::lw: return {{32{lane[31]}}, lane};
            bus_pkg::lwu: return {32'd0, lane};
            // ld low word, upper half filled on the second step
            default: return {32'd0, word};
        endcase
    endfunction

    // current word: fresh request, or the next word of a doubleword
    always_comb begin
        if (step == bus_pkg::second) begin
            active = 1'b1;
            wr = req_q.write;
            idx = req_q.index + 1'b1;
            wdata = req_q.data[63:32];
            lanes = 4'b1111;
        end else begin
            active = req.strobe;
            wr = req.write;
            idx = req.index;
            case (req.ls_type)
                bus_pkg::lb: begin
                    wdata = {4{req.data[7:0]}};
                    lanes = 4'b0001 << req.offset;
                end
                bus_pkg::lh: begin
                    wdata = {2{req.data[15:0]}};
                    lanes = req.offset[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    wdata = req.data[31:0];
                    lanes = 4'b1111;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (active && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // read side, also keeps the request for the second word
    always_ff @(posedge CLOCK_50) begin
        if (req.strobe) begin
            req_q <= req;
        end
        if (step == bus_pkg::second) begin
            data_q[63:32] <= mem[idx];
        end else if (req.strobe) begin
            data_q <= load_ext(mem[idx], req.ls_type, req.offset);
        end
    end

    // ld and sd share code 3
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step <= bus_pkg::first;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (step == bus_pkg::second) begin
                step <= bus_pkg::first;
                done_q <= 1'b1;
            end else if (req.strobe) begin
                if (req.ls_type == bus_pkg::ld) begin
                    step <= bus_pkg::second;
                end else begin
                    done_q <= 1'b1;
                end
            end
        end
    end

    assign rsp = '{done: done_q, data: data_q};

endmodule

/* hdl/plic.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module plic (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  irq_pkg::plic_req_t req,
    input  logic               irq_source,
    output logic [31:0]        rdata,
    output logic               meip,
    output logic               msip
);

    logic [`PRIO_BITS-1:0] prio_q;
    logic                  pending_q;
    // per context, only the source bit survives
    logic [1:0]            enable_q;
    logic [`PRIO_BITS-1:0] threshold_q [2];
    logic                  source_q;
    logic                  source_rise;
    logic [1:0]            eligible;
    logic [31:0]           claim_id;

    assign source_rise = irq_source && !source_q;

    // strictly above threshold, so threshold 7 masks everything
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            eligible[c] = pending_q && enable_q[c] && (prio_q > threshold_q[c]);
        end
    end

    assign claim_id = eligible[req.ctx] ? 32'(irq_pkg::SOURCE_ID) : 32'd0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio_q <= '0;
            pending_q <= 1'b0;
            enable_q <= '0;
            threshold_q[0] <= '0;
            threshold_q[1] <= '0;
            source_q <= 1'b0;
            meip <= 1'b0;
            msip <= 1'b0;
        end else begin
            source_q <= irq_source;
            meip <= eligible[irq_pkg::m_mode];
            msip <= eligible[irq_pkg::s_mode];
            if (req.write) begin
                case (req.sel)
                    irq_pkg::prio: prio_q <= req.wdata[`PRIO_BITS-1:0];
                    irq_pkg::enable: enable_q[req.ctx] <= req.wdata[irq_pkg::SOURCE_ID];
                    irq_pkg::threshold: threshold_q[req.ctx] <= req.wdata[`PRIO_BITS-1:0];
                    // completion
                    irq_pkg::claim: pending_q <= pending_q && (req.wdata != irq_pkg::SOURCE_ID);
                    default: pending_q <= pending_q;
                endcase
            end
            if (req.read && req.sel == irq_pkg::claim && claim_id != 0) begin
                pending_q <= 1'b0;
            end
            // new edge beats a same-cycle claim
            if (source_rise) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (req.read) begin
            case (req.sel)
                irq_pkg::prio: rdata <= 32'(prio_q);
                irq_pkg::pending: rdata <= {31'd0, pending_q} << irq_pkg::SOURCE_ID;
                irq_pkg::enable: rdata <= {31'd0, enable_q[req.ctx]} << irq_pkg::SOURCE_ID;
                irq_pkg::threshold: rdata <= 32'(threshold_q[req.ctx]);
                irq_pkg::claim: rdata <= claim_id;
                default: rdata <= '0;
            endcase
        end
    end

endmodule

/* hdl/soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus,
    output logic [63:0]       read_data,
    output logic              read_done,
    output logic              write_done,
    input  logic [63:0]       mtime,
    input  logic              irq_source,
    output logic              meip,
    output logic              msip
);

    bus_pkg::region_e   region;
    irq_pkg::plic_reg_e plic_reg;
    irq_pkg::context_e  plic_ctx;
    bus_pkg::ram_req_t  ram_req;
    bus_pkg::ram_rsp_t  ram_rsp;
    irq_pkg::plic_req_t plic_req;
    logic [31:0]        plic_rdata;

    // decode runs on the live address, sampled with the pulse
    addr_decoder addr_decoder_i (
        .address  (bus.address),
        .region   (region),
        .plic_reg (plic_reg),
        .plic_ctx (plic_ctx)
    );

    bus_controller bus_controller_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus        (bus),
        .region     (region),
        .plic_reg   (plic_reg),
        .plic_ctx   (plic_ctx),
        .mtime      (mtime),
        .ram_req    (ram_req),
        .ram_rsp    (ram_rsp),
        .plic_req   (plic_req),
        .plic_rdata (plic_rdata),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done)
    );

    ram_bank ram_bank_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (ram_req),
        .rsp      (ram_rsp)
    );

    plic plic_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (plic_req),
        .irq_source (irq_source),
        .rdata      (plic_rdata),
        .meip       (meip),
        .msip       (msip)
    );

endmodule

/* tests/soc_bus_tb.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module soc_bus_tb;

    localparam int RAM_OPS = 300;
    localparam int FLOW_ROUNDS = 24;
    // store plus maybe a load per ram step and about twenty accesses per irq round
    localparam int TOTAL_OPS = 2 * RAM_OPS + 20 * FLOW_ROUNDS + 80;
    localparam longint TIMEOUT_NS = longint'(TOTAL_OPS) * 10 * 40 + 20000;
    localparam logic [63:0] RAM_BASE = 64'(`RAM_BASE);
    localparam logic [63:0] PLIC = 64'(`PLIC_BASE);
    localparam logic [63:0] PRIO_ADDR = PLIC + 4 * irq_pkg::SOURCE_ID;
    localparam logic [63:0] PENDING_ADDR = PLIC + `PLIC_PENDING_OFF;
    localparam logic [63:0] SRC_BIT = 64'd1 << irq_pkg::SOURCE_ID;

    logic              CLOCK_50;
    logic              KEY0;
    bus_pkg::bus_req_t bus;
    logic [63:0]       read_data;
    logic              read_done;
    logic              write_done;
    logic [63:0]       mtime;
    logic              irq_source;
    logic              meip;
    logic              msip;

    // reference model state
    logic [7:0]        ram_model [4 * `RAM_WORDS];
    bit                written [4 * `RAM_WORDS];
    int unsigned       stored [$];
    logic [63:0]       mtimecmp_m;
    logic [2:0]        prio_m;
    logic              pending_m;
    logic              enable_m [2];
    logic [2:0]        thresh_m [2];

    soc_bus_top soc_bus_top_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus        (bus),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .mtime      (mtime),
        .irq_source (irq_source),
        .meip       (meip),
        .msip       (msip)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #20 CLOCK_50 = ~CLOCK_50;
        end
    end

    // hard stop if some access never finishes
    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired, the bus never completed an access");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // leaves the caller 2 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #2;
    endtask

    task automatic await_completion();
        while (!(read_done && write_done)) begin
            @(posedge CLOCK_50);
            #2;
        end
    endtask

    task automatic write_access(input logic [63:0] addr, input logic [63:0] data,
                                input logic [2:0] kind);
        bus.address = addr;
        bus.write_data = data;
        bus.ls_type = bus_pkg::ls_type_e'(kind);
        bus.write_enable = 1'b1;
        idle_cycles(1);
        bus.write_enable = 1'b0;
        compare_value("write_done low after pulse", 64'd0, 64'(write_done));
        await_completion();
    endtask

    task automatic read_access(input logic [63:0] addr, input logic [2:0] kind,
                               output logic [63:0] data);
        bus.address = addr;
        bus.ls_type = bus_pkg::ls_type_e'(kind);
        bus.read_enable = 1'b1;
        idle_cycles(1);
        bus.read_enable = 1'b0;
        compare_value("read_done low after pulse", 64'd0, 64'(read_done));
        await_completion();
        data = read_data;
    endtask

    function automatic int unsigned access_bytes(input logic [2:0] kind);
        case (kind[1:0])
            2'd0: return 1;
            2'd1: return 2;
            2'd2: return 4;
            default: return 8;
        endcase
    endfunction

    // little endian gather then extend by load type
    function automatic logic [63:0] model_load(input int unsigned off, input logic [2:0] kind);
        logic [63:0] raw;
        raw = '0;
        for (int b = 0; b < access_bytes(kind); b++) begin
            raw[8*b +: 8] = ram_model[off + b];
        end
        case (kind)
            3'd0: return {{56{raw[7]}}, raw[7:0]};
            3'd1: return {{48{raw[15]}}, raw[15:0]};
            3'd2: return {{32{raw[31]}}, raw[31:0]};
            3'd4: return {56'd0, raw[7:0]};
            3'd5: return {48'd0, raw[15:0]};
            3'd6: return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    function automatic logic [63:0] enable_addr(input int c);
        return PLIC + `PLIC_ENABLE_OFF + c * `PLIC_CTX_ENABLE_STRIDE;
    endfunction

    function automatic logic [63:0] threshold_addr(input int c);
        return PLIC + `PLIC_THRESHOLD_OFF + c * `PLIC_CTX_STRIDE;
    endfunction

    function automatic logic [63:0] claim_addr(input int c);
        return PLIC + `PLIC_CLAIM_OFF + c * `PLIC_CTX_STRIDE;
    endfunction

    // priority must be strictly above the context threshold
    function automatic logic eligible_for(input int c);
        return pending_m && enable_m[c] && (prio_m > thresh_m[c]);
    endfunction

    // no store starts in the last word so sd never wraps the index
    task automatic store_random();
        logic [2:0]  kind;
        logic [63:0] data;
        int unsigned off;
        kind = 3'($urandom_range(0, 3));
        data = {$urandom, $urandom};
        off = 4 * $urandom_range(0, `RAM_WORDS - 2);
        if (kind == 3'd0) begin
            off = off + $urandom_range(0, 3);
        end else if (kind == 3'd1) begin
            off = off + 2 * $urandom_range(0, 1);
        end
        write_access(RAM_BASE + off, data, kind);
        for (int b = 0; b < access_bytes(kind); b++) begin
            ram_model[off + b] = data[8*b +: 8];
            written[off + b] = 1'b1;
        end
        stored.push_back(off);
    endtask

    // aim near an earlier store and drop to lbu if some byte is still unknown
    task automatic load_random();
        int unsigned base;
        int unsigned off;
        int unsigned size;
        logic [2:0]  kind;
        logic [63:0] got;
        bit          known;
        base = stored[$urandom_range(0, stored.size() - 1)];
        kind = 3'($urandom_range(0, 6));
        size = access_bytes(kind);
        off = (size == 8) ? (base & ~32'd3) : (base & ~(size - 1));
        known = 1'b1;
        for (int b = 0; b < size; b++) begin
            if (!written[off + b]) begin
                known = 1'b0;
            end
        end
        if (!known) begin
            kind = 3'd4;
            off = base;
        end
        read_access(RAM_BASE + off, kind, got);
        compare_value($sformatf("ram load type %0d at offset %h", kind, off),
                      model_load(off, kind), got);
    endtask

    task automatic check_irq_outputs(input string name);
        idle_cycles(2);
        compare_value({name, " meip"}, 64'(eligible_for(0)), 64'(meip));
        compare_value({name, " msip"}, 64'(eligible_for(1)), 64'(msip));
    endtask

    task automatic pulse_source();
        irq_source = 1'b1;
        idle_cycles(1);
        irq_source = 1'b0;
        pending_m = 1'b1;
    endtask

    task automatic program_irq_regs();
        logic [63:0] data;
        prio_m = 3'($urandom_range(0, 7));
        write_access(PRIO_ADDR, 64'(prio_m), 3'd2);
        for (int c = 0; c < 2; c++) begin
            data = {32'd0, $urandom};
            enable_m[c] = data[irq_pkg::SOURCE_ID];
            write_access(enable_addr(c), data, 3'd2);
            thresh_m[c] = 3'($urandom_range(0, 7));
            write_access(threshold_addr(c), 64'(thresh_m[c]), 3'd2);
        end
    endtask

    initial begin
        logic [63:0] got;
        logic [63:0] data;
        int          c;
        bus = '0;
        mtime = '0;
        irq_source = 1'b0;
        KEY0 = 1'b0;
        void'($urandom(32'hce3cd542));
        mtimecmp_m = `MTIMECMP_RESET;
        prio_m = '0;
        pending_m = 1'b0;
        enable_m = '{1'b0, 1'b0};
        thresh_m = '{3'd0, 3'd0};

        idle_cycles(5);
        KEY0 = 1'b1;
        idle_cycles(1);

        // reset state
        compare_value("reset read_done", 64'd1, 64'(read_done));
        compare_value("reset write_done", 64'd1, 64'(write_done));
        compare_value("reset meip", 64'd0, 64'(meip));
        compare_value("reset msip", 64'd0, 64'(msip));
        read_access(`MTIMECMP_ADDR, 3'd3, got);
        compare_value("reset mtimecmp", mtimecmp_m, got);

        // ram traffic
        for (int i = 0; i < RAM_OPS; i++) begin
            store_random();
            if ($urandom_range(0, 1) == 1) begin
                load_random();
            end
        end

        // timer
        mtimecmp_m = {$urandom, $urandom};
        write_access(`MTIMECMP_ADDR, mtimecmp_m, 3'd3);
        read_access(`MTIMECMP_ADDR, 3'd3, got);
        compare_value("mtimecmp readback", mtimecmp_m, got);
        mtime = {$urandom, $urandom};
        read_access(`MTIME_ADDR, 3'd3, got);
        compare_value("mtime view", mtime, got);
        write_access(`MTIME_ADDR, {$urandom, $urandom}, 3'd3);
        read_access(`MTIME_ADDR, 3'd3, got);
        compare_value("mtime after write", mtime, got);
        read_access(`MTIMECMP_ADDR, 3'd3, got);
        compare_value("mtimecmp after mtime write", mtimecmp_m, got);

        // interrupt registers before any source edge
        read_access(PENDING_ADDR, 3'd2, got);
        compare_value("pending before edge", 64'd0, got);
        for (int i = 0; i < 8; i++) begin
            data = {32'd0, $urandom};
            write_access(PRIO_ADDR, data, 3'd2);
            read_access(PRIO_ADDR, 3'd2, got);
            compare_value("priority readback", data & 64'h7, got);
            // alternate so both contexts get covered
            c = i % 2;
            data = {32'd0, $urandom};
            write_access(enable_addr(c), data, 3'd2);
            read_access(enable_addr(c), 3'd2, got);
            compare_value($sformatf("enable ctx %0d readback", c), data & SRC_BIT, got);
            data = {32'd0, $urandom};
            write_access(threshold_addr(c), data, 3'd2);
            read_access(threshold_addr(c), 3'd2, got);
            compare_value($sformatf("threshold ctx %0d readback", c), data & 64'h7, got);
        end
        read_access(PENDING_ADDR, 3'd2, got);
        compare_value("pending after register writes", 64'd0, got);

        // interrupt flow
        for (int r = 0; r < FLOW_ROUNDS; r++) begin
            program_irq_regs();
            check_irq_outputs("after programming");
            pulse_source();
            check_irq_outputs("after source pulse");
            c = $urandom_range(0, 1);
            read_access(claim_addr(c), 3'd2, got);
            compare_value($sformatf("claim ctx %0d", c),
                          eligible_for(c) ? 64'(irq_pkg::SOURCE_ID) : 64'd0, got);
            if (eligible_for(c)) begin
                pending_m = 1'b0;
            end
            read_access(PENDING_ADDR, 3'd2, got);
            compare_value("pending after claim", pending_m ? SRC_BIT : 64'd0, got);
            check_irq_outputs("after claim");
            // completion path clears pending too
            pulse_source();
            write_access(claim_addr($urandom_range(0, 1)), 64'(irq_pkg::SOURCE_ID), 3'd2);
            pending_m = 1'b0;
            read_access(PENDING_ADDR, 3'd2, got);
            compare_value("pending after complete", 64'd0, got);
            check_irq_outputs("after complete");
        end

        // unmapped addresses
        read_access(64'h0, 3'd3, got);
        compare_value("unmapped read at zero", 64'd0, got);
        read_access(64'h2000_0000, 3'd2, got);
        compare_value("unmapped read high", 64'd0, got);
        read_access(PLIC + 8, 3'd2, got);
        compare_value("unused priority slot", 64'd0, got);
        // word 0 is where a wrapped ram index would land
        data = {$urandom, $urandom};
        write_access(RAM_BASE, data, 3'd3);
        for (int b = 0; b < 8; b++) begin
            ram_model[b] = data[8*b +: 8];
            written[b] = 1'b1;
        end
        write_access(RAM_BASE + 4 * `RAM_WORDS, {$urandom, $urandom}, 3'd3);
        write_access(PLIC + 8, {$urandom, $urandom}, 3'd2);
        read_access(RAM_BASE, 3'd3, got);
        compare_value("ram word 0 after unmapped write", data, got);
        for (int i = 0; i < 20; i++) begin
            load_random();
        end
        read_access(`MTIMECMP_ADDR, 3'd3, got);
        compare_value("mtimecmp after unmapped write", mtimecmp_m, got);
        read_access(PRIO_ADDR, 3'd2, got);
        compare_value("priority after unmapped write", 64'(prio_m), got);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/irq_pkg.sv
hdl/addr_decoder.sv
hdl/bus_controller.sv
hdl/ram_bank.sv
hdl/plic.sv
hdl/soc_bus_top.sv
tests/soc_bus_tb.sv
